// File: Makefile
TOP := tb_harness

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: bench/tb_harness.sv
`timescale 1ns/1ns
`default_nettype none

`include "harness_cfg.svh"

module tb_harness;

    localparam int NUM_VALUES   = 1 << `COUNTER_WIDTH;
    localparam int RESET_CYCLES = 16;
    // Two sweeps of about 1040 cycles each, the rest is room for frames under stalls
    localparam int MAX_CYCLES   = 6000;
    // No random corruption here, so the C0 and DB error frames are never overflowed
    localparam int QUIET_LO     = 'hC0 - 48;

    localparam logic [7:0] END_BYTE     = 8'hC0;
    localparam logic [7:0] ESC_BYTE     = 8'hDB;
    localparam logic [7:0] ESC_END_BYTE = 8'hDC;
    localparam logic [7:0] ESC_ESC_BYTE = 8'hDD;

    logic                      clk;
    logic                      had_reset;
    logic [`N_OUTPUTS-1:0]     dut_result;
    logic                      out_ready;
    logic [`COUNTER_WIDTH-1:0] stim;
    logic [7:0]                out_data;
    logic                      out_valid;
    logic                      run_restart;

    // Device model and expectations for the current run
    logic [`N_OUTPUTS-1:0] corrupt [NUM_VALUES];
    int                    pending [$];
    int                    mismatches;
    int                    err_frames;
    bit                    seen_c0;
    bit                    seen_db;
    bit                    expect_reset;

    // SLIP decoder
    logic [7:0] frame [$];
    bit         in_escape;

    int errors;
    int completions;
    int run_idx;
    int cycles;
    bit finished;

    harness_top uut (
        .clk         (clk),
        .had_reset   (had_reset),
        .dut_result  (dut_result),
        .out_ready   (out_ready),
        .stim        (stim),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .run_restart (run_restart)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic expect_equal(input int got, input int exp, input string what);
        assert (got == exp) else begin
            errors++;
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic require(input bit ok, input string what);
        assert (ok) else begin
            errors++;
            $display("Failure at %0t: %s", $time, what);
        end
    endtask

    // New corruption pattern and a fresh mismatch list
    task automatic start_run();
        logic [`N_OUTPUTS-1:0] m;
        pending.delete();
        mismatches   = 0;
        err_frames   = 0;
        seen_c0      = 1'b0;
        seen_db      = 1'b0;
        expect_reset = 1'b1;
        for (int v = 0; v < NUM_VALUES; v++) begin
            m = '0;
            // Forced masks carry a SLIP byte in their low byte as well
            if (v == 'hC0) begin
                m = `N_OUTPUTS'({$urandom, 8'hC0});
            end else if (v == 'hDB) begin
                m = `N_OUTPUTS'({$urandom, 8'hDB});
            end else if (v >= QUIET_LO && v < 'hDB) begin
                m = '0;
            end else if (($urandom % 64) == 0) begin
                m = `N_OUTPUTS'($urandom);
                if (m == '0) begin
                    m = `N_OUTPUTS'(1);
                end
            end
            corrupt[v] = m;
            if (m != '0) begin
                pending.push_back(v);
                mismatches++;
            end
        end
    endtask

    task automatic judge_frame();
        int got_count;
        int got_mask;
        int total;
        int overflows;
        if (expect_reset) begin
            expect_equal(frame.size(), 1, "reset frame length");
            expect_equal(int'(frame[0]), 0, "reset frame id");
            expect_reset = 1'b0;
        end else if (frame[0] == 8'h01) begin
            expect_equal(frame.size(), 5, "error frame length");
            err_frames++;
            if (frame.size() == 5) begin
                got_count = int'({frame[2], frame[1]});
                got_mask  = int'({frame[4], frame[3]});
                // Unreported errors were overflowed, drop them
                while (pending.size() > 0 && pending[0] != got_count) begin
                    void'(pending.pop_front());
                end
                require(pending.size() > 0, $sformatf(
                    "error frame names count %0h, which is not a pending corrupted value",
                    got_count));
                if (pending.size() > 0) begin
                    void'(pending.pop_front());
                    expect_equal(got_mask, int'(corrupt[got_count]), "error frame mask");
                    if (got_count == 'hC0) begin
                        seen_c0 = 1'b1;
                    end
                    if (got_count == 'hDB) begin
                        seen_db = 1'b1;
                    end
                end
            end
        end else if (frame[0] == 8'h02) begin
            expect_equal(frame.size(), 5, "completion frame length");
            if (frame.size() == 5) begin
                total     = int'({frame[2], frame[1]});
                overflows = int'({frame[4], frame[3]});
                expect_equal(total, mismatches, "total error count");
                expect_equal(overflows, mismatches - err_frames, "overflow count");
            end
            require(seen_c0 && seen_db, "error frames for counts C0 and DB were not both seen");
            completions++;
            if (completions == 2) begin
                finished = 1'b1;
            end
        end else begin
            require(1'b0, $sformatf("frame with unknown id %02h", frame[0]));
        end
    endtask

    task automatic decode_byte(input logic [7:0] b);
        if (in_escape) begin
            in_escape = 1'b0;
            require(b == ESC_END_BYTE || b == ESC_ESC_BYTE,
                $sformatf("byte %02h follows an escape", b));
            frame.push_back(b == ESC_END_BYTE ? END_BYTE : ESC_BYTE);
        end else if (b == END_BYTE) begin
            if (frame.size() > 0) begin
                judge_frame();
            end
            frame.delete();
        end else if (b == ESC_BYTE) begin
            in_escape = 1'b1;
        end else begin
            frame.push_back(b);
        end
    endtask

    // Everything is settled at the falling edge; a byte moves at the next rising edge
    always @(negedge clk) begin
        if (out_valid && out_ready) begin
            decode_byte(out_data);
        end
    end

    initial begin
        void'($urandom(32'h4430_fb99));
        had_reset   = 1'b1;
        dut_result  = '0;
        out_ready   = 1'b0;
        errors      = 0;
        completions = 0;
        run_idx     = 0;
        cycles      = 0;
        finished    = 1'b0;
        in_escape   = 1'b0;
        start_run();

        while (!finished && cycles < MAX_CYCLES) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles == RESET_CYCLES) begin
                had_reset = 1'b0;
            end
            if (run_restart) begin
                expect_equal(completions, run_idx + 1, "completion frames before restart");
                run_idx++;
                start_run();
            end
            dut_result = `N_OUTPUTS'(int'(stim) * 3) ^ corrupt[stim];
            if (!had_reset) begin
                out_ready = ($urandom % 4) != 0;
            end
        end

        if (!finished) begin
            $display("Timeout after %0d cycles with %0d of 2 runs complete",
                cycles, completions);
        end
        $display("Errors: %0d, runs completed: %0d", errors, completions);
        if (errors == 0 && finished) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+src
src/harness_pkg.sv
src/check_if.sv
src/tx_if.sv
src/stimulus_counter.sv
src/result_compare.sv
src/frame_generator.sv
src/slip_encoder.sv
src/reset_controller.sv
src/harness_top.sv
bench/tb_harness.sv

// File: src/check_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "harness_cfg.svh"

// Compare results, one beat per vector, no back-pressure
interface check_if;
    logic                      valid;
    logic [`COUNTER_WIDTH-1:0] count;
    logic                      error;
    logic [`N_OUTPUTS-1:0]     error_output;
    logic                      done;

    modport source (output valid, count, error, error_output, done);
    modport sink   (input valid, count, error, error_output, done);
endinterface

`default_nettype wire

// File: src/frame_generator.sv
`timescale 1ns/1ns
`default_nettype none

`include "harness_cfg.svh"

module frame_generator (
    input  logic    clk,
    input  logic    core_reset,
    check_if.sink   chk,
    tx_if.source    tx,
    input  logic    tx_idle,
    output logic    do_reset
);

    import harness_pkg::*;

    localparam int COUNT_BYTES = (`COUNTER_WIDTH + 7) / 8;
    localparam int MASK_BYTES  = (`N_OUTPUTS + 7) / 8;
    localparam int STAT_BYTES  = (`STAT_WIDTH + 7) / 8;

    frame_state_t              state;
    logic                      reset_pending;
    logic                      had_error;
    logic                      err_last;
    logic [`COUNTER_WIDTH-1:0] err_count;
    logic [`N_OUTPUTS-1:0]     err_mask;
    logic [`STAT_WIDTH-1:0]    num_errors;
    logic [`STAT_WIDTH-1:0]    num_overflows;
    logic [3:0]                byte_idx;
    logic                      tx_accept;
    logic                      tx_free;
    logic                      latch_clear;
    logic                      latch_free;

    // Byte idx of a field, low byte first
    function automatic logic [7:0] pick_byte(input logic [63:0] value, input logic [3:0] idx);
        return 8'(value >> (8 * idx));
    endfunction

    assign tx_accept   = tx.valid && tx.ready;
    assign tx_free     = !tx.valid || tx.ready;
    assign latch_clear = err_last && tx_accept;
    assign latch_free  = !had_error || latch_clear;

    // Error statistics and the single error latch
    always_ff @(posedge clk) begin
        if (core_reset) begin
            had_error     <= 1'b0;
            num_errors    <= '0;
            num_overflows <= '0;
        end else begin
            if (latch_clear) begin
                had_error <= 1'b0;
            end
            if (chk.valid && chk.error) begin
                if (num_errors != {`STAT_WIDTH{1'b1}}) begin
                    num_errors <= num_errors + 1'b1;
                end
                if (latch_free) begin
                    had_error <= 1'b1;
                end else if (num_overflows != {`STAT_WIDTH{1'b1}}) begin
                    num_overflows <= num_overflows + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (chk.valid && chk.error && latch_free) begin
            err_count <= chk.count;
            err_mask  <= chk.error_output;
        end
    end

    always_ff @(posedge clk) begin
        if (core_reset) begin
            state         <= IDLE;
            reset_pending <= 1'b1;
            err_last      <= 1'b0;
            byte_idx      <= '0;
            tx.valid      <= 1'b0;
            tx.data       <= '0;
            tx.sof        <= 1'b0;
            tx.eof        <= 1'b0;
            do_reset      <= 1'b0;
        end else begin
            if (tx_accept) begin
                tx.valid <= 1'b0;
                err_last <= 1'b0;
            end

            case (state)
                IDLE: begin
                    byte_idx <= '0;
                    // Hold off while the last error byte is still in flight
                    if (reset_pending) begin
                        state <= RESET_FRAME;
                    end else if (had_error && !err_last) begin
                        state <= ERROR_ID;
                    end else if (chk.done && !had_error) begin
                        state <= COMPLETE_ID;
                    end
                end
                RESET_FRAME: begin
                    if (tx_free) begin
                        tx.data       <= RESET;
                        tx.valid      <= 1'b1;
                        tx.sof        <= 1'b1;
                        tx.eof        <= 1'b1;
                        reset_pending <= 1'b0;
                        state         <= IDLE;
                    end
                end
                ERROR_ID: begin
                    if (tx_free) begin
                        tx.data  <= ERROR;
                        tx.valid <= 1'b1;
                        tx.sof   <= 1'b1;
                        tx.eof   <= 1'b0;
                        state    <= ERROR_COUNT;
                    end
                end
                ERROR_COUNT: begin
                    if (tx_free) begin
                        tx.data  <= pick_byte(64'(err_count), byte_idx);
                        tx.valid <= 1'b1;
                        tx.sof   <= 1'b0;
                        if (byte_idx == 4'(COUNT_BYTES - 1)) begin
                            byte_idx <= '0;
                            state    <= ERROR_VALUE;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                ERROR_VALUE: begin
                    if (tx_free) begin
                        tx.data  <= pick_byte(64'(err_mask), byte_idx);
                        tx.valid <= 1'b1;
                        if (byte_idx == 4'(MASK_BYTES - 1)) begin
                            tx.eof   <= 1'b1;
                            err_last <= 1'b1;
                            state    <= IDLE;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                COMPLETE_ID: begin
                    if (tx_free) begin
                        tx.data  <= COMPLETE;
                        tx.valid <= 1'b1;
                        tx.sof   <= 1'b1;
                        tx.eof   <= 1'b0;
                        state    <= TOTAL_COUNT;
                    end
                end
                TOTAL_COUNT: begin
                    if (tx_free) begin
                        tx.data  <= pick_byte(64'(num_errors), byte_idx);
                        tx.valid <= 1'b1;
                        tx.sof   <= 1'b0;
                        if (byte_idx == 4'(STAT_BYTES - 1)) begin
                            byte_idx <= '0;
                            state    <= OVERFLOW_COUNT;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                OVERFLOW_COUNT: begin
                    if (tx_free) begin
                        tx.data  <= pick_byte(64'(num_overflows), byte_idx);
                        tx.valid <= 1'b1;
                        if (byte_idx == 4'(STAT_BYTES - 1)) begin
                            tx.eof <= 1'b1;
                            state  <= WAIT_FLUSH;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                WAIT_FLUSH: begin
                    // Stay here until the reset controller restarts the run
                    if (!tx.valid && tx_idle) begin
                        do_reset <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_tx_hold: assert property (
        @(posedge clk) disable iff (core_reset)
        tx.valid && !tx.ready |=> tx.valid && $stable(tx.data) && $stable(tx.sof)
            && $stable(tx.eof)
    ) else $error("tx byte changed while stalled");

endmodule

`default_nettype wire

// File: src/harness_cfg.svh
`ifndef HARNESS_CFG_SVH
`define HARNESS_CFG_SVH

// Stimulus sweep width, also the width of the count in error frames
`define COUNTER_WIDTH 10

// Width of the device result and of the mismatch mask
`define N_OUTPUTS 10

// Error and overflow counters saturate at this width
`define STAT_WIDTH 16

// Core reset hold time in cycles
`define RESET_HOLD 16

`endif

// File: src/harness_pkg.sv
`default_nettype none

package harness_pkg;

    // First byte of every frame
    typedef enum logic [7:0] {
        RESET    = 8'd0,
        ERROR    = 8'd1,
        COMPLETE = 8'd2
    } frame_id_t;

    // Frame generator FSM
    typedef enum logic [3:0] {
        IDLE,
        RESET_FRAME,
        ERROR_ID,
        ERROR_COUNT,
        ERROR_VALUE,
        COMPLETE_ID,
        TOTAL_COUNT,
        OVERFLOW_COUNT,
        WAIT_FLUSH
    } frame_state_t;

    // SLIP framing bytes
    localparam logic [7:0] SLIP_END     = 8'hC0;
    localparam logic [7:0] SLIP_ESC     = 8'hDB;
    localparam logic [7:0] SLIP_ESC_END = 8'hDC;
    localparam logic [7:0] SLIP_ESC_ESC = 8'hDD;

endpackage

`default_nettype wire

// File: src/harness_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "harness_cfg.svh"

module harness_top (
    input  logic                      clk,
    input  logic                      had_reset,
    input  logic [`N_OUTPUTS-1:0]     dut_result,
    input  logic                      out_ready,
    output logic [`COUNTER_WIDTH-1:0] stim,
    output logic [7:0]                out_data,
    output logic                      out_valid,
    output logic                      run_restart
);

    logic                      core_reset;
    logic                      saturated;
    logic                      do_reset;
    logic                      tx_idle;
    logic [`COUNTER_WIDTH-1:0] count;

    check_if chk_bus ();
    tx_if    tx_bus ();

    // Device sees the sweep value directly
    assign stim = count;

    reset_controller u_reset (
        .clk         (clk),
        .had_reset   (had_reset),
        .do_reset    (do_reset),
        .core_reset  (core_reset),
        .run_restart (run_restart)
    );

    stimulus_counter u_stim (
        .clk        (clk),
        .core_reset (core_reset),
        .count      (count),
        .saturated  (saturated)
    );

    result_compare u_compare (
        .clk        (clk),
        .core_reset (core_reset),
        .count      (count),
        .saturated  (saturated),
        .dut_result (dut_result),
        .chk        (chk_bus.source)
    );

    frame_generator u_frames (
        .clk        (clk),
        .core_reset (core_reset),
        .chk        (chk_bus.sink),
        .tx         (tx_bus.source),
        .tx_idle    (tx_idle),
        .do_reset   (do_reset)
    );

    slip_encoder u_slip (
        .clk        (clk),
        .core_reset (core_reset),
        .tx         (tx_bus.sink),
        .tx_idle    (tx_idle),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

// File: src/reset_controller.sv
`timescale 1ns/1ns
`default_nettype none

`include "harness_cfg.svh"

module reset_controller (
    input  logic clk,
    input  logic had_reset,
    input  logic do_reset,
    output logic core_reset,
    output logic run_restart
);

    localparam int HOLD_W = $clog2(`RESET_HOLD + 1);

    logic [HOLD_W-1:0] hold;

    always_ff @(posedge clk) begin
        if (had_reset) begin
            hold        <= HOLD_W'(`RESET_HOLD);
            core_reset  <= 1'b1;
            run_restart <= 1'b0;
        end else if (do_reset && !core_reset) begin
            // Self-reset request at the end of a run
            hold        <= HOLD_W'(`RESET_HOLD);
            core_reset  <= 1'b1;
            run_restart <= 1'b1;
        end else begin
            run_restart <= 1'b0;
            if (hold != '0) begin
                hold <= hold - 1'b1;
            end
            core_reset <= (hold > HOLD_W'(1));
        end
    end

endmodule

`default_nettype wire

// File: src/result_compare.sv
`timescale 1ns/1ns
`default_nettype none

`include "harness_cfg.svh"

module result_compare (
    input  logic                      clk,
    input  logic                      core_reset,
    input  logic [`COUNTER_WIDTH-1:0] count,
    input  logic                      saturated,
    input  logic [`N_OUTPUTS-1:0]     dut_result,
    check_if.source                   chk
);

    logic [`N_OUTPUTS-1:0] expected;
    logic [`N_OUTPUTS-1:0] diff;

    // Golden function, three times the stimulus, wrapped to the result width
    assign expected = `N_OUTPUTS'(count) * `N_OUTPUTS'(3);
    assign diff     = expected ^ dut_result;

    always_ff @(posedge clk) begin
        if (core_reset) begin
            chk.valid <= 1'b0;
            chk.done  <= 1'b0;
        end else begin
            chk.valid <= !saturated;
            if (saturated) begin
                chk.done <= 1'b1;
            end
        end
    end

    // Beat payload
    always_ff @(posedge clk) begin
        chk.count        <= count;
        chk.error        <= |diff;
        chk.error_output <= diff;
    end

    // Once done, the stream stays quiet until reset
    a_done_quiet: assert property (
        @(posedge clk) disable iff (core_reset)
        chk.done |-> !chk.valid ##1 chk.done
    ) else $error("check beat issued after done");

endmodule

`default_nettype wire

// File: src/slip_encoder.sv
`timescale 1ns/1ns
`default_nettype none

module slip_encoder (
    input  logic       clk,
    input  logic       core_reset,
    tx_if.sink         tx,
    output logic       tx_idle,
    output logic [7:0] out_data,
    output logic       out_valid,
    input  logic       out_ready
);

    import harness_pkg::*;

    logic       out_free;
    logic       esc_pending;
    logic [7:0] esc_byte;
    logic       end_pending;
    logic       in_frame;

    assign out_free = !out_valid || out_ready;
    assign tx.ready = out_free && !esc_pending && !end_pending;
    assign tx_idle  = !out_valid && !esc_pending && !end_pending;

    always_ff @(posedge clk) begin
        if (core_reset) begin
            out_valid   <= 1'b0;
            esc_pending <= 1'b0;
            end_pending <= 1'b0;
            in_frame    <= 1'b0;
        end else if (out_free) begin
            if (esc_pending) begin
                // Second half of an escape
                out_data    <= esc_byte;
                out_valid   <= 1'b1;
                esc_pending <= 1'b0;
            end else if (end_pending) begin
                out_data    <= SLIP_END;
                out_valid   <= 1'b1;
                end_pending <= 1'b0;
            end else if (tx.valid) begin
                out_valid   <= 1'b1;
                end_pending <= tx.eof;
                in_frame    <= !tx.eof;
                case (tx.data)
                    SLIP_END: begin
                        out_data    <= SLIP_ESC;
                        esc_byte    <= SLIP_ESC_END;
                        esc_pending <= 1'b1;
                    end
                    SLIP_ESC: begin
                        out_data    <= SLIP_ESC;
                        esc_byte    <= SLIP_ESC_ESC;
                        esc_pending <= 1'b1;
                    end
                    default: out_data <= tx.data;
                endcase
            end else begin
                out_valid <= 1'b0;
            end
        end
    end

    a_out_hold: assert property (
        @(posedge clk) disable iff (core_reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("out_data changed under stall");

    // Frame markers from the generator must alternate cleanly
    a_sof_framing: assert property (
        @(posedge clk) disable iff (core_reset)
        tx.valid && tx.ready |-> tx.sof == !in_frame
    ) else $error("sof does not match frame boundary");

endmodule

`default_nettype wire

// File: src/stimulus_counter.sv
`timescale 1ns/1ns
`default_nettype none

`include "harness_cfg.svh"

module stimulus_counter (
    input  logic                      clk,
    input  logic                      core_reset,
    output logic [`COUNTER_WIDTH-1:0] count,
    output logic                      saturated
);

    logic at_max;

    assign at_max = (count == {`COUNTER_WIDTH{1'b1}});

    always_ff @(posedge clk) begin
        if (core_reset) begin
            count     <= '0;
            saturated <= 1'b0;
        end else begin
            if (!at_max) begin
                count <= count + 1'b1;
            end
            // Lags the last value by a cycle so it still gets compared
            if (at_max) begin
                saturated <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/tx_if.sv
`timescale 1ns/1ns
`default_nettype none

// Frame bytes with start and end markers, valid/ready handshake
interface tx_if;
    logic [7:0] data;
    logic       valid;
    logic       ready;
    logic       sof;
    logic       eof;

    modport source (output data, valid, sof, eof, input ready);
    modport sink   (input data, valid, sof, eof, output ready);
endinterface

`default_nettype wire
